//--- rtl/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

`define CACHE_NUM_WAY        2
`define CACHE_BYTES_PER_LINE 16
`define CACHE_NUM_LINE       256
`define CACHE_WORDS_PER_LINE (`CACHE_BYTES_PER_LINE / 4)

// split of a 32-bit byte address
`define CACHE_OFFSET_W $clog2(`CACHE_BYTES_PER_LINE)
`define CACHE_INDEX_W  $clog2(`CACHE_NUM_LINE)
`define CACHE_TAG_W    (32 - `CACHE_OFFSET_W - `CACHE_INDEX_W)
`define CACHE_BANK_W   $clog2(`CACHE_WORDS_PER_LINE)

// victim lfsr start value, must be nonzero
`define CACHE_LFSR_SEED 4'h9

`endif

//--- rtl/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;
    typedef logic [`CACHE_BANK_W-1:0]   bank_t; // word within a line

    typedef logic [`CACHE_NUM_WAY-1:0] way_t; // one-hot
    typedef logic [`CACHE_BYTES_PER_LINE*8-1:0] line_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        DIRTY_MISS,
        REPLACE,
        REFILL
    } cache_state_t;

endpackage

//--- rtl/cache_table_if.sv
interface cache_table_if;
    import cache_pkg::*;

    index_t index; // lookup port
    tag_t   tag;
    bank_t  bank;

    logic   write; // data write port
    index_t write_index;
    way_t   write_way;
    bank_t  write_bank;
    word_t  write_data;
    strb_t  write_strb;

    way_t   tag_v_write_way;
    tag_t   tag_write;
    way_t   d_write_way;
    logic   d_write;

    way_t   read_way; // victim select

    way_t   hit_way;
    way_t   v_ways;
    way_t   dirty_ways;
    word_t  rdata;
    line_t  read_line;
    tag_t   read_tag;

    modport ctrl (
        output index, tag, bank,
        output write, write_index, write_way, write_bank, write_data, write_strb,
        output tag_v_write_way, tag_write, d_write_way, d_write, read_way,
        input  hit_way, v_ways, dirty_ways, rdata, read_line, read_tag
    );

    modport tbl (
        input  index, tag, bank,
        input  write, write_index, write_way, write_bank, write_data, write_strb,
        input  tag_v_write_way, tag_write, d_write_way, d_write, read_way,
        output hit_way, v_ways, dirty_ways, rdata, read_line, read_tag
    );
endinterface

//--- rtl/write_buf_if.sv
interface write_buf_if;
    import cache_pkg::*;

    logic   pending; // store waiting for its table write
    index_t index;
    way_t   way;
    bank_t  bank;
    word_t  data;
    strb_t  strb;

    modport wbuf (
        output pending,
        output index,
        output way,
        output bank,
        output data,
        output strb
    );

    modport ctrl (
        input pending,
        input index,
        input way,
        input bank,
        input data,
        input strb
    );
endinterface

//--- rtl/cache_table.sv
`include "cache_defines.svh"

module cache_table (
    input  logic clk,
    input  logic reset,
    cache_table_if.tbl tbl
);
    import cache_pkg::*;

    tag_t tags [`CACHE_NUM_WAY][`CACHE_NUM_LINE];
    logic [`CACHE_NUM_LINE-1:0] valid_bits [`CACHE_NUM_WAY];
    logic [`CACHE_NUM_LINE-1:0] dirty_bits [`CACHE_NUM_WAY];
    word_t data [`CACHE_NUM_WAY][`CACHE_WORDS_PER_LINE][`CACHE_NUM_LINE];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `CACHE_NUM_WAY; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
            end
        end else begin
            for (int w = 0; w < `CACHE_NUM_WAY; w++) begin
                if (tbl.tag_v_write_way[w]) begin
                    valid_bits[w][tbl.write_index] <= 1'b1;
                end
                if (tbl.d_write_way[w]) begin
                    dirty_bits[w][tbl.write_index] <= tbl.d_write;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_NUM_WAY; w++) begin
            if (tbl.tag_v_write_way[w]) begin
                tags[w][tbl.write_index] <= tbl.tag_write;
            end
            if (tbl.write && tbl.write_way[w]) begin
                for (int b = 0; b < 4; b++) begin
                    if (tbl.write_strb[b]) begin // byte lanes
                        data[w][tbl.write_bank][tbl.write_index][8*b +: 8]
                            <= tbl.write_data[8*b +: 8];
                    end
                end
            end
        end
    end

    // all reads straight from the arrays
    always_comb begin
        tbl.hit_way    = '0;
        tbl.v_ways     = '0;
        tbl.dirty_ways = '0;
        tbl.rdata      = '0;
        tbl.read_line  = '0;
        tbl.read_tag   = '0;
        for (int w = 0; w < `CACHE_NUM_WAY; w++) begin
            tbl.v_ways[w]     = valid_bits[w][tbl.index];
            tbl.dirty_ways[w] = dirty_bits[w][tbl.index];
            tbl.hit_way[w]    = valid_bits[w][tbl.index] && (tags[w][tbl.index] == tbl.tag);
            if (tbl.hit_way[w]) begin
                tbl.rdata = tbl.rdata | data[w][tbl.bank][tbl.index];
            end
            if (tbl.read_way[w]) begin
                tbl.read_tag = tags[w][tbl.index];
                for (int b = 0; b < `CACHE_WORDS_PER_LINE; b++) begin
                    tbl.read_line[32*b +: 32] = data[w][b][tbl.index];
                end
            end
        end
    end

    // a refill must never leave the same tag valid in two ways of a set
    hit_way_onehot0: assert property (
        @(posedge clk) disable iff (reset || $isunknown(tbl.index))
        $onehot0(tbl.hit_way)
    );

endmodule

//--- rtl/replace_way_gen.sv
`include "cache_defines.svh"

module replace_way_gen (
    input  logic clk,
    input  logic reset,
    input  logic miss,
    input  cache_pkg::way_t v_ways,
    output cache_pkg::way_t replace_way
);
    import cache_pkg::*;

    logic [3:0] lfsr;
    way_t free_ways;
    way_t lowest_free;
    way_t rand_way;

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= `CACHE_LFSR_SEED;
        end else if (miss) begin
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]}; // x^4 + x^3 + 1
        end
    end

    assign free_ways   = ~v_ways;
    assign lowest_free = free_ways & (~free_ways + 1'b1);
    assign rand_way    = way_t'(1) << (lfsr % `CACHE_NUM_WAY);
    assign replace_way = (|free_ways) ? lowest_free : rand_way;

    // ctrl relies on a single victim when it registers the replace buffer
    victim_onehot: assert property (
        @(posedge clk) disable iff (reset)
        miss |-> $onehot(replace_way)
    );

endmodule

//--- rtl/write_buffer.sv
module write_buffer (
    input  logic clk,
    input  logic reset,
    input  logic store_hit,
    input  cache_pkg::way_t hit_way,
    input  cache_pkg::index_t lookup_index,
    input  cache_pkg::bank_t lookup_bank,
    input  cache_pkg::word_t wdata,
    input  cache_pkg::strb_t wstrb,
    input  cache_pkg::bank_t in_bank,
    output cache_pkg::strb_t fwd_strb,
    output logic conflict,
    write_buf_if.wbuf wb
);
    import cache_pkg::*;

    word_t stage_data;
    strb_t stage_strb;
    logic fwd_match;

    // cpu write data delayed one cycle to line up with LOOKUP
    always_ff @(posedge clk) begin
        stage_data <= wdata;
        stage_strb <= wstrb;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.pending <= 1'b0;
        end else begin
            wb.pending <= store_hit; // one cycle only
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            wb.index <= lookup_index;
            wb.way   <= hit_way;
            wb.bank  <= lookup_bank;
            wb.data  <= stage_data;
            wb.strb  <= stage_strb;
        end
    end

    assign conflict  = wb.pending && (wb.bank == in_bank);
    assign fwd_match = wb.pending && (wb.index == lookup_index)
                       && (wb.way == hit_way) && (wb.bank == lookup_bank);
    assign fwd_strb  = fwd_match ? wb.strb : '0;

endmodule

//--- rtl/cache_ctrl.sv
module cache_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic valid,
    input  logic write,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::strb_t wstrb,
    input  cache_pkg::word_t wdata,
    output logic addr_ok,
    output logic data_ok,
    output cache_pkg::word_t rdata,
    output logic rd_req,
    output cache_pkg::addr_t rd_addr,
    input  logic rd_rdy,
    input  logic ret_valid,
    input  logic ret_last,
    input  cache_pkg::word_t ret_data,
    output logic wr_req,
    output cache_pkg::addr_t wr_addr,
    output cache_pkg::line_t wr_data,
    input  logic wr_rdy,
    cache_table_if.ctrl tbl,
    write_buf_if.ctrl wb,
    output cache_pkg::index_t lookup_index,
    output cache_pkg::bank_t lookup_bank,
    output logic store_hit,
    output cache_pkg::way_t hit_way,
    input  cache_pkg::strb_t fwd_strb,
    input  logic conflict,
    output logic miss,
    input  cache_pkg::way_t replace_way
);
    import cache_pkg::*;

    cache_state_t state;
    cache_state_t state_next;
    tag_t in_tag;
    index_t in_index;
    offset_t in_offset;
    tag_t req_tag;
    index_t req_index;
    bank_t req_bank;
    logic req_write;
    strb_t req_wstrb;
    word_t req_wdata;
    tag_t repl_tag;
    index_t repl_index;
    bank_t repl_bank;
    logic repl_write;
    strb_t repl_wstrb;
    word_t repl_wdata;
    way_t repl_way;
    bank_t refill_cnt;
    logic first_replace;
    logic hit;
    logic accept;
    logic victim_dirty;
    logic refill_own_word;
    logic lookup_data_ok;
    logic refill_data_ok;
    word_t lookup_rdata;
    word_t merged_ret;
    word_t refill_word;

    assign {in_tag, in_index, in_offset} = addr;

    assign hit    = (state == LOOKUP) && (|tbl.hit_way);
    assign accept = valid && !conflict && ((state == IDLE) || hit);
    // a store still in the write buffer has not set its dirty bit yet
    assign victim_dirty = (|(tbl.dirty_ways & replace_way))
                          || (wb.pending && (wb.index == req_index) && (wb.way == replace_way));

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (accept) state_next = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    state_next = accept ? LOOKUP : IDLE;
                end else begin
                    state_next = victim_dirty ? DIRTY_MISS : MISS;
                end
            end
            MISS:       if (rd_rdy) state_next = REFILL;
            DIRTY_MISS: if (wr_rdy) state_next = REPLACE;
            REPLACE:    if (rd_rdy) state_next = REFILL;
            REFILL:     if (ret_valid && ret_last) state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            first_replace <= 1'b0;
            refill_cnt    <= '0;
        end else begin
            state         <= state_next;
            first_replace <= (state == DIRTY_MISS) && wr_rdy;
            if (state != REFILL) begin
                refill_cnt <= '0;
            end else if (ret_valid) begin
                refill_cnt <= refill_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_next == LOOKUP) begin // request buffer
            req_tag   <= in_tag;
            req_index <= in_index;
            req_bank  <= bank_t'(in_offset >> 2);
            req_write <= write;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
        if (state == LOOKUP) begin // replace buffer
            repl_tag   <= req_tag;
            repl_index <= req_index;
            repl_bank  <= req_bank;
            repl_write <= req_write;
            repl_wstrb <= req_wstrb;
            repl_wdata <= req_wdata;
            repl_way   <= replace_way;
        end
    end

    assign refill_own_word = (repl_bank == refill_cnt);
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            lookup_rdata[8*b +: 8] = fwd_strb[b] ? wb.data[8*b +: 8] : tbl.rdata[8*b +: 8];
            merged_ret[8*b +: 8]   = repl_wstrb[b] ? repl_wdata[8*b +: 8] : ret_data[8*b +: 8];
        end
    end
    assign refill_word = (repl_write && refill_own_word) ? merged_ret : ret_data;

    // refill owns the write ports, otherwise the write buffer
    always_comb begin
        if (state == REFILL) begin
            tbl.write           = ret_valid;
            tbl.write_index     = repl_index;
            tbl.write_way       = repl_way;
            tbl.write_bank      = refill_cnt;
            tbl.write_data      = refill_word;
            tbl.write_strb      = '1;
            tbl.tag_v_write_way = repl_way;
            tbl.d_write_way     = repl_way;
            tbl.d_write         = repl_write; // write miss leaves line dirty
        end else begin
            tbl.write           = wb.pending;
            tbl.write_index     = wb.index;
            tbl.write_way       = wb.way;
            tbl.write_bank      = wb.bank;
            tbl.write_data      = wb.data;
            tbl.write_strb      = wb.strb;
            tbl.tag_v_write_way = '0;
            tbl.d_write_way     = wb.pending ? wb.way : '0;
            tbl.d_write         = 1'b1;
        end
    end
    assign tbl.tag_write = repl_tag;
    assign tbl.index     = (state == LOOKUP) ? req_index : repl_index;
    assign tbl.tag       = req_tag;
    assign tbl.bank      = req_bank;
    assign tbl.read_way  = repl_way;

    assign lookup_index = req_index;
    assign lookup_bank  = req_bank;
    assign hit_way      = tbl.hit_way;
    assign store_hit    = hit && req_write;
    assign miss         = (state == LOOKUP) && !(|tbl.hit_way);

    assign addr_ok        = accept;
    assign lookup_data_ok = (state == LOOKUP) && (hit || req_write); // writes never wait
    assign refill_data_ok = (state == REFILL) && ret_valid && refill_own_word && !repl_write;
    assign data_ok        = lookup_data_ok || refill_data_ok;
    assign rdata          = lookup_data_ok ? lookup_rdata : ret_data;

    assign rd_req  = (state == MISS) || (state == REPLACE);
    assign rd_addr = {repl_tag, repl_index, offset_t'(0)};
    assign wr_req  = first_replace;
    assign wr_addr = {tbl.read_tag, repl_index, offset_t'(0)};
    assign wr_data = tbl.read_line;

    wr_req_in_replace: assert property (
        @(posedge clk) disable iff (reset)
        wr_req |-> (state == REPLACE)
    );

    no_data_ok_in_miss: assert property (
        @(posedge clk) disable iff (reset)
        (state inside {MISS, DIRTY_MISS}) |-> !data_ok
    );

endmodule

//--- rtl/cache_top.sv
`include "cache_defines.svh"

module cache_top (
    input  logic clk,
    input  logic reset,
    input  logic valid,
    input  logic write,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::strb_t wstrb,
    input  cache_pkg::word_t wdata,
    output logic addr_ok,
    output logic data_ok,
    output cache_pkg::word_t rdata,
    output logic rd_req,
    output cache_pkg::addr_t rd_addr,
    input  logic rd_rdy,
    input  logic ret_valid,
    input  logic ret_last,
    input  cache_pkg::word_t ret_data,
    output logic wr_req,
    output cache_pkg::addr_t wr_addr,
    output cache_pkg::line_t wr_data,
    input  logic wr_rdy
);
    import cache_pkg::*;

    index_t lookup_index;
    bank_t lookup_bank;
    bank_t in_bank;
    logic store_hit;
    way_t hit_way;
    strb_t fwd_strb;
    logic conflict;
    logic miss;
    way_t replace_way;

    cache_table_if tbl_if ();
    write_buf_if wb_if ();

    assign in_bank = addr[`CACHE_OFFSET_W-1:2]; // bank of the incoming request

    cache_ctrl cache_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .valid        (valid),
        .write        (write),
        .addr         (addr),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_rdy       (wr_rdy),
        .tbl          (tbl_if.ctrl),
        .wb           (wb_if.ctrl),
        .lookup_index (lookup_index),
        .lookup_bank  (lookup_bank),
        .store_hit    (store_hit),
        .hit_way      (hit_way),
        .fwd_strb     (fwd_strb),
        .conflict     (conflict),
        .miss         (miss),
        .replace_way  (replace_way)
    );

    cache_table cache_table_i (
        .clk   (clk),
        .reset (reset),
        .tbl   (tbl_if.tbl)
    );

    write_buffer write_buffer_i (
        .clk          (clk),
        .reset        (reset),
        .store_hit    (store_hit),
        .hit_way      (hit_way),
        .lookup_index (lookup_index),
        .lookup_bank  (lookup_bank),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .in_bank      (in_bank),
        .fwd_strb     (fwd_strb),
        .conflict     (conflict),
        .wb           (wb_if.wbuf)
    );

    replace_way_gen replace_way_gen_i (
        .clk         (clk),
        .reset       (reset),
        .miss        (miss),
        .v_ways      (tbl_if.v_ways),
        .replace_way (replace_way)
    );

endmodule

//--- tests/mem_model.sv
module mem_model #(
    parameter logic [31:0] SEED = 32'hb428_bb4b
) (
    input  logic clk,
    input  logic reset,
    input  logic rd_req,
    input  cache_pkg::addr_t rd_addr,
    output logic rd_rdy,
    output logic ret_valid,
    output logic ret_last,
    output cache_pkg::word_t ret_data,
    input  logic wr_req,
    input  cache_pkg::addr_t wr_addr,
    input  cache_pkg::line_t wr_data,
    output logic wr_rdy
);
    import cache_pkg::*;

    word_t mem [addr_t]; // word-aligned keys, written lines only
    logic [31:0] lfsr = SEED;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // contents of a word never written back
    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic word_t read_word(input addr_t a);
        addr_t k;
        k = {a[31:2], 2'b00};
        return mem.exists(k) ? mem[k] : fill_word(k);
    endfunction

    initial begin
        addr_t line_addr;
        logic [1:0] stall;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            wr_rdy = take_bits(1);
            if (!reset && wr_req) begin
                for (int b = 0; b < 4; b++) begin
                    mem[{wr_addr[31:4], 4'h0} + 4 * b] = wr_data[32*b +: 32];
                end
            end
            if (!reset && rd_req) begin
                stall     = take_bits(2);
                line_addr = {rd_addr[31:4], 4'h0};
                repeat (stall) begin
                    @(posedge clk);
                    #2;
                end
                rd_rdy = 1'b1;
                @(posedge clk);
                #2;
                rd_rdy = 1'b0;
                for (int b = 0; b < 4; b++) begin // burst from word 0
                    ret_valid = 1'b1;
                    ret_last  = (b == 3);
                    ret_data  = read_word(line_addr + 4 * b);
                    @(posedge clk);
                    #2;
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
                ret_data  = '0;
            end
        end
    end

endmodule

//--- tests/cache_tb.sv
module cache_tb;
    import cache_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 150;
    localparam logic [31:0] LFSR_SEED = 32'hb428_bb4b;
    localparam logic [19:0] TAGS [4] = '{20'h00012, 20'h00345, 20'h0a7c1, 20'hfff00};
    localparam logic [7:0] INDICES [4] = '{8'h00, 8'h01, 8'h5a, 8'hff};

    logic clk;
    logic reset;
    logic valid;
    logic write;
    addr_t addr;
    strb_t wstrb;
    word_t wdata;
    logic addr_ok;
    logic data_ok;
    word_t rdata;
    logic rd_req;
    addr_t rd_addr;
    logic rd_rdy;
    logic ret_valid;
    logic ret_last;
    word_t ret_data;
    logic wr_req;
    addr_t wr_addr;
    line_t wr_data;
    logic wr_rdy;

    logic [31:0] lfsr = LFSR_SEED;
    word_t shadow [addr_t]; // word-aligned keys
    int errors = 0;
    int accepted = 0;
    int reads_checked = 0;
    int writebacks = 0;
    logic stim_on = 1'b0;

    logic pend_write [4]; // accepted, waiting for data_ok
    word_t pend_word [4];
    logic [1:0] head = '0;
    logic [1:0] tail = '0;
    int pend_cnt = 0;
    addr_t last_addr = '0;
    logic last_read = 1'b0;
    logic refill_open = 1'b0;

    // expectations for the current cycle, refreshed at the falling edge
    logic head_write = 1'b1;
    word_t head_word = '0;
    int cnt_now = 0;
    logic expect_hit = 1'b0;
    logic busy_now = 1'b0;
    line_t exp_wr_line = '0;

    cache_top cache_top_i (.*);
    mem_model #(.SEED(LFSR_SEED)) mem_model_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // same fill rule as the memory model
    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic word_t stored_word(input addr_t a);
        addr_t k;
        k = {a[31:2], 2'b00};
        return shadow.exists(k) ? shadow[k] : fill_word(k);
    endfunction

    function automatic line_t expected_line(input addr_t a);
        line_t l;
        for (int b = 0; b < 4; b++) begin
            l[32*b +: 32] = stored_word({a[31:4], 4'h0} + 4 * b);
        end
        return l;
    endfunction

    function automatic addr_t pick_addr();
        logic [1:0] t;
        logic [1:0] i;
        logic [1:0] b;
        t = take_bits(2);
        i = take_bits(2);
        b = take_bits(2);
        return {TAGS[t], INDICES[i], b, 2'b00};
    endfunction

    task automatic log_mismatch(input string name, input line_t got, input line_t exp);
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic fail_check(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // called 2 units after a rising edge, returns at the same point after acceptance
    task automatic send_request(input logic w, input addr_t a, input strb_t s, input word_t d);
        valid = 1'b1;
        write = w;
        addr  = a;
        wstrb = s;
        wdata = d;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pend_cnt != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    always @(negedge clk) begin : track
        word_t merged;
        head_write = pend_write[head];
        head_word  = pend_word[head];
        cnt_now    = pend_cnt;
        expect_hit = !write && last_read && (addr == last_addr);
        busy_now   = rd_req || wr_req || refill_open;
        if (!reset && wr_req) begin
            exp_wr_line = expected_line(wr_addr);
            writebacks++;
        end
        if (!reset && data_ok && pend_cnt > 0) begin
            if (!pend_write[head]) reads_checked++;
            head = head + 1'b1;
            pend_cnt--;
        end
        if (!reset && addr_ok) begin
            pend_write[tail] = write;
            pend_word[tail]  = write ? '0 : stored_word(addr);
            tail = tail + 1'b1;
            pend_cnt++;
            accepted++;
            if (write) begin
                merged = stored_word(addr);
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) merged[8*b +: 8] = wdata[8*b +: 8];
                end
                shadow[{addr[31:2], 2'b00}] = merged;
            end
            last_addr = addr;
            last_read = !write;
        end
        if (!reset && rd_req && rd_rdy) refill_open = 1'b1;
        if (!reset && ret_valid && ret_last) refill_open = 1'b0;
    end

    quiet_after_reset: assert property (
        @(posedge clk) disable iff (reset)
        !stim_on |-> !(addr_ok || data_ok || rd_req || wr_req)
    ) else fail_check("handshake output active before stimulus started");

    read_data: assert property (
        @(posedge clk) disable iff (reset)
        data_ok && cnt_now > 0 && !head_write |-> rdata == head_word
    ) else log_mismatch("rdata", $sampled(rdata), $sampled(head_word));

    data_ok_owned: assert property (
        @(posedge clk) disable iff (reset)
        data_ok |-> cnt_now > 0
    ) else fail_check("data_ok with no request outstanding");

    in_flight: assert property (
        @(posedge clk) disable iff (reset)
        cnt_now <= 2
    ) else fail_check("more than two requests in flight");

    hit_timing: assert property (
        @(posedge clk) disable iff (reset)
        addr_ok && expect_hit |=> data_ok && !rd_req
    ) else fail_check("repeated read did not complete one cycle after acceptance");

    writeback_data: assert property (
        @(posedge clk) disable iff (reset)
        wr_req |-> wr_data == exp_wr_line
    ) else log_mismatch("wr_data", $sampled(wr_data), $sampled(exp_wr_line));

    wr_req_pulse: assert property (
        @(posedge clk) disable iff (reset)
        wr_req |=> !wr_req
    ) else fail_check("wr_req held longer than one cycle");

    rd_req_held: assert property (
        @(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr)
    ) else fail_check("rd_req dropped or rd_addr changed before rd_rdy");

    no_accept_busy: assert property (
        @(posedge clk) disable iff (reset)
        busy_now |-> !addr_ok
    ) else fail_check("request accepted while a memory transfer was outstanding");

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout: run still going after %0d cycles", NUM_TESTS * 200);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [1:0] kind;
        addr_t a;
        strb_t s;
        logic w;
        word_t d;
        reset = 1'b1;
        valid = 1'b0;
        write = 1'b0;
        addr  = '0;
        wstrb = '0;
        wdata = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (4) @(posedge clk); // outputs must stay quiet here
        #2;
        stim_on = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            kind = take_bits(2);
            a = pick_addr();
            s = take_bits(4);
            if (s == '0) s = 4'hf;
            w = take_bits(1);
            d = take_bits(32);
            case (kind)
                2'd0: send_request(w, a, s, d);
                2'd1: begin // store then load of the same word
                    send_request(1'b1, a, s, d);
                    send_request(1'b0, a, 4'h0, '0);
                end
                2'd2: begin
                    send_request(1'b0, a, 4'h0, '0);
                    wait_drain();
                    send_request(1'b0, a, 4'h0, '0);
                end
                default: begin
                    send_request(w, a, s, d);
                    send_request(!w, pick_addr(), s, ~d);
                end
            endcase
            if (take_bits(1)) wait_drain();
        end
        wait_drain();
        repeat (4) @(posedge clk); // late stray data_ok still trips the checks
        $display("summary: %0d requests, %0d reads checked, %0d writebacks, %0d errors",
                 accepted, reads_checked, writebacks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_table_if.sv
rtl/write_buf_if.sv
rtl/cache_table.sv
rtl/replace_way_gen.sv
rtl/write_buffer.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
tests/mem_model.sv
tests/cache_tb.sv
